// File: src/lspcPkg.sv
package lspcPkg;

	// Raster geometry
	localparam int LINE_LEN    = 384;	// Clocks per line
	localparam int FRAME_LINES = 264;	// Lines per frame
	localparam int VBLANK_LINE = 248;	// First vblank line

	// Timer run window when PAL stop is on
	localparam int PAL_TOP    = 16;
	localparam int PAL_BOTTOM = 248;	// Exclusive

	// VRAM geometry
	localparam int VRAM_WORDS = 32768;
	localparam int VRAM_AW    = $clog2(VRAM_WORDS);	// Low address bits that index the array

	// Host word offsets
	localparam logic [2:0] REG_VRAMADDR  = 3'd0;
	localparam logic [2:0] REG_VRAMDATA  = 3'd1;
	localparam logic [2:0] REG_VRAMMOD   = 3'd2;
	localparam logic [2:0] REG_MODE      = 3'd3;
	localparam logic [2:0] REG_TIMERHI   = 3'd4;
	localparam logic [2:0] REG_TIMERLO   = 3'd5;
	localparam logic [2:0] REG_IRQACK    = 3'd6;
	localparam logic [2:0] REG_TIMERSTOP = 3'd7;

	// Offset 3 is written as control and read back as status
	typedef union packed
	{
		struct packed
		{
			logic [7:0] aaSpeed;	// Frames per animation step
			logic [2:0] timerMode;	// Reload on LSB write, frame, zero
			logic       timerIrqEn;
			logic       aaDisable;
			logic [2:0] unused;
		} ctrl;
		struct packed
		{
			logic [8:0] vCount;	// Current raster line
			logic [2:0] zero;
			logic       videoMode;	// 0 is NTSC
			logic [2:0] aaCount;
		} status;
	} lspcMode_u;

endpackage

// File: src/lspcRegs.sv
`timescale 1ns/1ps

module lspcRegs
	import lspcPkg::*;
(
	input  logic        CLK,
	input  logic        nRESET,
	input  logic [2:0]  addr,
	input  logic [15:0] wrData,
	input  logic        wrEn,
	input  logic        rdEn,
	input  logic [15:0] readBuffer,
	input  logic [15:0] vramMod,
	input  logic [8:0]  vCount,
	input  logic [2:0]  aaCount,
	output logic [15:0] rdData,
	output logic        vramAddrWr,
	output logic        vramDataWr,
	output logic        vramModWr,
	output logic [31:0] timerLoad,
	output logic        loadLoWr,
	output logic [2:0]  timerMode,
	output logic        timerIrqEn,
	output logic        timerPalStop,
	output logic [7:0]  aaSpeed,
	output logic        aaDisable,
	output logic        ackWr
);

	lspcMode_u modeWr;	// Control view of the bus word
	lspcMode_u modeRd;	// Status view for read-back

	assign modeWr = wrData;

	// Strobes to the VRAM port and irq block, same cycle as wrEn
	assign vramAddrWr = wrEn && (addr == REG_VRAMADDR);
	assign vramDataWr = wrEn && (addr == REG_VRAMDATA);
	assign vramModWr  = wrEn && (addr == REG_VRAMMOD);
	assign ackWr      = wrEn && (addr == REG_IRQACK);

	always_comb
	begin
		modeRd = '0;
		modeRd.status.vCount    = vCount;
		modeRd.status.videoMode = 1'b0;	// NTSC only
		modeRd.status.aaCount   = aaCount;
	end

	always_ff @(posedge CLK)
	begin
		if (!nRESET)
		begin
			aaSpeed      <= '0;
			timerMode    <= '0;
			timerIrqEn   <= 1'b0;
			aaDisable    <= 1'b0;
			timerLoad    <= '0;
			timerPalStop <= 1'b0;
			loadLoWr     <= 1'b0;
		end
		else
		begin
			// Delayed so the timer sees the full new reload value
			loadLoWr <= wrEn && (addr == REG_TIMERLO);
			if (wrEn)
			begin
				case (addr)
					REG_MODE:
					begin
						aaSpeed    <= modeWr.ctrl.aaSpeed;
						timerMode  <= modeWr.ctrl.timerMode;
						timerIrqEn <= modeWr.ctrl.timerIrqEn;
						aaDisable  <= modeWr.ctrl.aaDisable;
					end
					REG_TIMERHI:   timerLoad[31:16] <= wrData;
					REG_TIMERLO:   timerLoad[15:0]  <= wrData;
					REG_TIMERSTOP: timerPalStop     <= wrData[0];
					default:       ;	// VRAM ports and ack handled by strobes
				endcase
			end
		end
	end

	// Read-back, one cycle after rdEn
	always_ff @(posedge CLK)
	begin
		if (!nRESET)
			rdData <= '0;
		else if (rdEn)
		begin
			case (addr)
				REG_VRAMADDR, REG_VRAMDATA,
				REG_TIMERHI, REG_TIMERLO: rdData <= readBuffer;
				REG_VRAMMOD, REG_IRQACK:  rdData <= vramMod;
				default:                  rdData <= modeRd;	// Offsets 3 and 7
			endcase
		end
	end

	// Host never reads and writes in one cycle
	assert property (@(posedge CLK) disable iff (!nRESET) !(wrEn && rdEn));

endmodule

// File: src/vramPort.sv
`timescale 1ns/1ps

module vramPort
	import lspcPkg::*;
(
	input  logic        CLK,
	input  logic        nRESET,
	input  logic [15:0] wrData,
	input  logic        vramAddrWr,
	input  logic        vramDataWr,
	input  logic        vramModWr,
	output logic [15:0] readBuffer,
	output logic [15:0] vramMod
);

	logic [15:0] vram [VRAM_WORDS];
	logic [15:0] vramAddr;	// Bit 15 is a kept zone bit
	logic        refill;	// Prefetch from the updated address
	logic [VRAM_AW-1:0] addrStep;

	// Only the low bits advance, the top bit stays put
	assign addrStep = vramAddr[VRAM_AW-1:0] + vramMod[VRAM_AW-1:0];

	always_ff @(posedge CLK)
	begin
		if (vramDataWr)
			vram[vramAddr[VRAM_AW-1:0]] <= wrData;	// Store before the address moves
	end

	always_ff @(posedge CLK)
	begin
		if (!nRESET)
		begin
			vramAddr <= '0;
			vramMod  <= '0;
			refill   <= 1'b0;
		end
		else
		begin
			refill <= vramAddrWr || vramDataWr;
			if (vramAddrWr)
				vramAddr <= wrData;
			else if (vramDataWr)
				vramAddr <= {vramAddr[15], addrStep};
			if (vramModWr)
				vramMod <= wrData;
		end
	end

	// Read buffer lands one cycle after the address settles
	always_ff @(posedge CLK)
	begin
		if (!nRESET)
			readBuffer <= '0;
		else if (refill)
			readBuffer <= vram[vramAddr[VRAM_AW-1:0]];
	end

	// Zone bit survives every data write
	assert property (@(posedge CLK) disable iff (!nRESET)
		vramDataWr |=> (vramAddr[15] == $past(vramAddr[15])));

endmodule

// File: src/lspcTimer.sv
`timescale 1ns/1ps

module lspcTimer
	import lspcPkg::*;
(
	input  logic        CLK,
	input  logic        nRESET,
	input  logic [31:0] timerLoad,
	input  logic        loadLoWr,
	input  logic [2:0]  timerMode,
	input  logic [8:0]  hCount,
	input  logic [8:0]  vCount,
	input  logic        frameStart,
	input  logic        timerPalStop,
	output logic        timerZero
);

	logic [31:0] count;
	logic [8:0]  nextLine;	// Line after the current one
	logic        inWindow;	// Current line lies inside the PAL run window
	logic        run;
	logic        zeroHit;	// Decrement from 1 this cycle
	logic        reloadNow;

	assign nextLine = (vCount == FRAME_LINES - 1) ? 9'd0 : vCount + 9'd1;

	// Window flag follows the line, looked up one clock early
	always_ff @(posedge CLK)
	begin
		if (!nRESET)
			inWindow <= 1'b0;	// Line 0 is above the window
		else if (hCount == LINE_LEN - 1)
			inWindow <= (nextLine >= PAL_TOP) && (nextLine < PAL_BOTTOM);
	end

	always_comb
	begin
		run       = (count != 0) && (!timerPalStop || inWindow);
		zeroHit   = run && (count == 32'd1);
		reloadNow = (loadLoWr && timerMode[0]) || (frameStart && timerMode[1]);
	end

	always_ff @(posedge CLK)
	begin
		if (!nRESET)
		begin
			count     <= '0;
			timerZero <= 1'b0;
		end
		else
		begin
			timerZero <= zeroHit && !reloadNow;	// One-cycle pulse
			if (reloadNow)
				count <= timerLoad;	// LSB write or frame reload
			else if (zeroHit)
				count <= timerMode[2] ? timerLoad : 32'd0;	// Repeat mode
			else if (run)
				count <= count - 32'd1;
		end
	end

endmodule

// File: src/videoCounters.sv
`timescale 1ns/1ps

module videoCounters
	import lspcPkg::*;
(
	input  logic       CLK,
	input  logic       nRESET,
	input  logic [7:0] aaSpeed,
	input  logic       aaDisable,
	output logic [8:0] hCount,
	output logic [8:0] vCount,
	output logic       frameStart,
	output logic [2:0] aaCount
);

	logic       lineEnd;
	logic       lastLine;
	logic [7:0] aaTimer;	// Frames left before next animation step

	assign lineEnd  = (hCount == LINE_LEN - 1);
	assign lastLine = (vCount == FRAME_LINES - 1);

	always_ff @(posedge CLK)
	begin
		if (!nRESET)
		begin
			hCount     <= '0;
			vCount     <= '0;
			frameStart <= 1'b0;
		end
		else
		begin
			frameStart <= lineEnd && lastLine;	// High with vCount back at 0
			if (lineEnd)
			begin
				hCount <= '0;
				vCount <= lastLine ? 9'd0 : vCount + 9'd1;
			end
			else
				hCount <= hCount + 9'd1;
		end
	end

	// Auto-animation divider
	always_ff @(posedge CLK)
	begin
		if (!nRESET)
		begin
			aaTimer <= '0;
			aaCount <= '0;
		end
		else if (frameStart)
		begin
			if (aaTimer == 8'd0)
			begin
				aaTimer <= aaSpeed;
				if (!aaDisable)
					aaCount <= aaCount + 3'd1;	// Wraps at 8
			end
			else
				aaTimer <= aaTimer - 8'd1;
		end
	end

endmodule

// File: src/irqCtrl.sv
`timescale 1ns/1ps

module irqCtrl
	import lspcPkg::*;
(
	input  logic       CLK,
	input  logic       nRESET,
	input  logic [8:0] vCount,
	input  logic [8:0] hCount,
	input  logic       timerZero,
	input  logic       timerIrqEn,
	input  logic       ackWr,
	input  logic [2:0] wrData,	// Ack mask
	output logic       irqVblank,
	output logic       irqTimer,
	output logic       irqBoot
);

	logic vblankSet;
	logic timerSet;

	assign vblankSet = (vCount == VBLANK_LINE) && (hCount == 9'd0);
	assign timerSet  = timerZero && timerIrqEn;

	// Set beats ack in the same cycle
	always_ff @(posedge CLK)
	begin
		if (!nRESET)
		begin
			irqBoot   <= 1'b1;	// Cold boot flag
			irqTimer  <= 1'b0;
			irqVblank <= 1'b0;
		end
		else
		begin
			if (ackWr && wrData[0])
				irqBoot <= 1'b0;
			if (timerSet)
				irqTimer <= 1'b1;
			else if (ackWr && wrData[1])
				irqTimer <= 1'b0;
			if (vblankSet)
				irqVblank <= 1'b1;
			else if (ackWr && wrData[2])
				irqVblank <= 1'b0;
		end
	end

	// Timer irq only from an enabled timer
	assert property (@(posedge CLK) disable iff (!nRESET) $rose(irqTimer) |-> $past(timerIrqEn));

endmodule

// File: src/lspcCore.sv
`timescale 1ns/1ps

module lspcCore
(
	input  logic        CLK,
	input  logic        nRESET,
	input  logic [2:0]  addr,
	input  logic [15:0] wrData,
	input  logic        wrEn,
	input  logic        rdEn,
	output logic [15:0] rdData,
	output logic        irqVblank,
	output logic        irqTimer,
	output logic        irqBoot
);

	// VRAM port
	logic [15:0] readBuffer;
	logic [15:0] vramMod;
	logic        vramAddrWr;
	logic        vramDataWr;
	logic        vramModWr;

	// Timer
	logic [31:0] timerLoad;
	logic        loadLoWr;
	logic [2:0]  timerMode;
	logic        timerIrqEn;
	logic        timerPalStop;
	logic        timerZero;

	// Raster and animation
	logic [8:0]  hCount;
	logic [8:0]  vCount;
	logic        frameStart;
	logic [7:0]  aaSpeed;
	logic        aaDisable;
	logic [2:0]  aaCount;

	logic        ackWr;

	lspcRegs i_regs (
		.CLK(CLK), .nRESET(nRESET),
		.addr(addr), .wrData(wrData), .wrEn(wrEn), .rdEn(rdEn),
		.readBuffer(readBuffer), .vramMod(vramMod), .vCount(vCount), .aaCount(aaCount),
		.rdData(rdData),
		.vramAddrWr(vramAddrWr), .vramDataWr(vramDataWr), .vramModWr(vramModWr),
		.timerLoad(timerLoad), .loadLoWr(loadLoWr), .timerMode(timerMode),
		.timerIrqEn(timerIrqEn), .timerPalStop(timerPalStop),
		.aaSpeed(aaSpeed), .aaDisable(aaDisable), .ackWr(ackWr)
	);

	vramPort i_vram (
		.CLK(CLK), .nRESET(nRESET), .wrData(wrData),
		.vramAddrWr(vramAddrWr), .vramDataWr(vramDataWr), .vramModWr(vramModWr),
		.readBuffer(readBuffer), .vramMod(vramMod)
	);

	videoCounters i_video (
		.CLK(CLK), .nRESET(nRESET), .aaSpeed(aaSpeed), .aaDisable(aaDisable),
		.hCount(hCount), .vCount(vCount), .frameStart(frameStart), .aaCount(aaCount)
	);

	lspcTimer i_timer (
		.CLK(CLK), .nRESET(nRESET), .timerLoad(timerLoad), .loadLoWr(loadLoWr),
		.timerMode(timerMode), .hCount(hCount), .vCount(vCount),
		.frameStart(frameStart), .timerPalStop(timerPalStop), .timerZero(timerZero)
	);

	irqCtrl i_irq (
		.CLK(CLK), .nRESET(nRESET), .vCount(vCount), .hCount(hCount),
		.timerZero(timerZero), .timerIrqEn(timerIrqEn),
		.ackWr(ackWr), .wrData(wrData[2:0]),	// Ack mask in low bits
		.irqVblank(irqVblank), .irqTimer(irqTimer), .irqBoot(irqBoot)
	);

endmodule

// File: sim/tbLspc.sv
`timescale 1ns/1ps

module tbLspc
	import lspcPkg::*;
();

	logic        CLK;
	logic        nRESET;
	logic [2:0]  addr;
	logic [15:0] wrData;
	logic        wrEn;
	logic        rdEn;
	logic [15:0] rdData;
	logic        irqVblank;
	logic        irqTimer;
	logic        irqBoot;

	int errors;
	int checks;
	bit monitorOn;	// Per-cycle irq compare

	// Reference model state
	int          cyc;	// Clocks since reset release
	logic [8:0]  mH;
	logic [8:0]  mV;
	logic        mFrameStart;
	lspcMode_u   mMode;	// Last control word
	logic [31:0] mLoad;
	logic        mLoadLo;
	logic [31:0] mCount;
	logic        mZero;
	logic        reload;
	logic [7:0]  mAaTimer;
	logic [2:0]  mAaCount;
	logic [15:0] mAddr;
	logic [15:0] mMod;
	logic [15:0] vramModel [VRAM_WORDS];
	logic [2:0]  mIrq;	// {vblank, timer, boot}
	logic [2:0]  ack;

	lspcCore i_dut (
		.CLK(CLK), .nRESET(nRESET), .addr(addr), .wrData(wrData), .wrEn(wrEn), .rdEn(rdEn),
		.rdData(rdData), .irqVblank(irqVblank), .irqTimer(irqTimer), .irqBoot(irqBoot)
	);

	always #4 CLK = ~CLK;

	// Raster position straight from the clock count
	assign mH          = 9'(cyc % LINE_LEN);
	assign mV          = 9'((cyc / LINE_LEN) % FRAME_LINES);
	assign mFrameStart = (cyc != 0) && (mH == 9'd0) && (mV == 9'd0);
	assign reload      = (mLoadLo && mMode.ctrl.timerMode[0]) ||
	                     (mFrameStart && mMode.ctrl.timerMode[1]);
	assign ack         = (wrEn && addr == REG_IRQACK) ? wrData[2:0] : 3'b000;

	always @(posedge CLK)
	begin
		if (!nRESET)
		begin
			cyc      <= 0;
			mMode    <= '0;
			mLoad    <= '0;
			mLoadLo  <= 1'b0;
			mCount   <= '0;
			mZero    <= 1'b0;
			mAaTimer <= '0;
			mAaCount <= '0;
			mAddr    <= '0;
			mMod     <= '0;
			mIrq     <= 3'b001;	// Boot flag only
		end
		else
		begin
			cyc     <= cyc + 1;
			mLoadLo <= wrEn && (addr == REG_TIMERLO);	// Timer sees it a cycle late
			if (wrEn)
			begin
				case (addr)
					REG_VRAMADDR: mAddr <= wrData;
					REG_VRAMDATA:
					begin
						vramModel[mAddr[14:0]] <= wrData;
						mAddr <= {mAddr[15], mAddr[14:0] + mMod[14:0]};	// Bit 15 stays
					end
					REG_VRAMMOD:  mMod <= wrData;
					REG_MODE:     mMode <= wrData;
					REG_TIMERHI:  mLoad[31:16] <= wrData;
					REG_TIMERLO:  mLoad[15:0] <= wrData;
					default:      ;
				endcase
			end
			// Animation step once per aaSpeed+1 frames
			if (mFrameStart)
			begin
				mAaTimer <= (mAaTimer == 8'd0) ? mMode.ctrl.aaSpeed : mAaTimer - 8'd1;
				if (mAaTimer == 8'd0 && !mMode.ctrl.aaDisable)
					mAaCount <= mAaCount + 3'd1;
			end
			mZero <= (mCount == 32'd1) && !reload;
			if (reload)
				mCount <= mLoad;
			else if (mCount == 32'd1)
				mCount <= mMode.ctrl.timerMode[2] ? mLoad : 32'd0;	// Repeat or stop
			else if (mCount != 32'd0)
				mCount <= mCount - 32'd1;
			// Sets win over acks
			mIrq[0] <= mIrq[0] && !ack[0];
			mIrq[1] <= (mZero && mMode.ctrl.timerIrqEn) || (mIrq[1] && !ack[1]);
			mIrq[2] <= (mV == 9'(VBLANK_LINE) && mH == 9'd0) || (mIrq[2] && !ack[2]);
		end
	end

	always @(negedge CLK)
	begin
		if (monitorOn)
			checkIrq({irqVblank, irqTimer, irqBoot}, mIrq);
	end

	task automatic checkWord(input string name, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic checkMode(input lspcMode_u got, input lspcMode_u exp);
		checkWord("status.vCount", 16'(got.status.vCount), 16'(exp.status.vCount));
		checkWord("status.zero", 16'(got.status.zero), 16'(exp.status.zero));
		checkWord("status.videoMode", 16'(got.status.videoMode), 16'(exp.status.videoMode));
		checkWord("status.aaCount", 16'(got.status.aaCount), 16'(exp.status.aaCount));
	endtask

	task automatic checkIrq(input logic [2:0] got, input logic [2:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] %0t irq {vblank,timer,boot} got %b expected %b", $time, got, exp);
		end
	endtask

	task automatic writeReg(input logic [2:0] a, input logic [15:0] d);
		addr   = a;
		wrData = d;
		wrEn   = 1'b1;
		@(negedge CLK);
		wrEn   = 1'b0;
	endtask

	task automatic readReg(input logic [2:0] a, output logic [15:0] d);
		addr = a;
		rdEn = 1'b1;
		@(negedge CLK);
		rdEn = 1'b0;
		d    = rdData;	// Registered on the edge in between
	endtask

	// Status expected from the cycle that rdEn is sampled
	task automatic readStatus(input logic [2:0] a);
		lspcMode_u exp;
		logic [15:0] d;
		exp = '0;
		exp.status.vCount  = mV;
		exp.status.aaCount = mAaCount;
		readReg(a, d);
		checkMode(d, exp);
	endtask

	task automatic waitLine(input int line);
		int n;
		n = 0;
		while (mV != 9'(line) && n < LINE_LEN * FRAME_LINES)
		begin
			@(negedge CLK);
			n++;
		end
		if (mV != 9'(line))
		begin
			errors++;
			$display("Timeout waiting for raster line %0d", line);
		end
	endtask

	initial
	begin
		logic [15:0] data;
		logic [15:0] got;
		logic [15:0] vAddr;
		logic [15:0] addrQ [$];
		int unsigned seed;
		int unsigned len;
		int unsigned lat;
		CLK       = 1'b0;
		nRESET    = 1'b0;
		addr      = '0;
		wrData    = '0;
		wrEn      = 1'b0;
		rdEn      = 1'b0;
		errors    = 0;
		checks    = 0;
		monitorOn = 1'b0;
		seed      = $urandom(32'hd4db_4fa8);
		repeat (10) @(negedge CLK);
		nRESET    = 1'b1;
		monitorOn = 1'b1;

		// Reset state
		checkIrq({irqVblank, irqTimer, irqBoot}, 3'b001);
		readStatus(REG_MODE);

		// Modulo read-back at both offsets
		repeat (8)
		begin
			data = 16'($urandom);
			writeReg(REG_VRAMMOD, data);
			readReg(REG_VRAMMOD, got);
			checkWord("vramMod at 2", got, data);
			readReg(REG_IRQACK, got);
			checkWord("vramMod at 6", got, data);
		end

		// VRAM bursts, then read back word by word
		repeat (4)
		begin
			writeReg(REG_VRAMMOD, 16'($urandom));
			writeReg(REG_VRAMADDR, 16'($urandom));
			len = $urandom_range(4, 12);
			repeat (len)
			begin
				addrQ.push_back(mAddr);
				writeReg(REG_VRAMDATA, 16'($urandom));
			end
			while (addrQ.size() > 0)
			begin
				vAddr = addrQ.pop_front();
				writeReg(REG_VRAMADDR, vAddr);
				@(negedge CLK);	// Buffer refill
				readReg(REG_VRAMADDR, got);
				checkWord("readBuffer", got, vramModel[vAddr[14:0]]);
			end
		end

		// Animation counter across frames
		repeat (3)
		begin
			writeReg(REG_MODE, {8'($urandom_range(0, 2)), 3'b000, 1'b0, 1'($urandom), 3'b000});
			waitLine(VBLANK_LINE);
			waitLine(0);
			repeat ($urandom_range(0, 20000)) @(negedge CLK);
			readStatus(REG_MODE);
			readStatus(REG_TIMERSTOP);
		end

		// Timer irq latency, reload on LSB write
		repeat (4)
		begin
			len = $urandom_range(1, 40);
			writeReg(REG_IRQACK, 16'h0002);
			writeReg(REG_MODE, 16'h0030);	// Mode 1, irq on
			writeReg(REG_TIMERHI, 16'h0000);
			writeReg(REG_TIMERLO, 16'(len));
			lat = 0;
			while (!irqTimer && lat < 100)
			begin
				@(negedge CLK);
				lat++;
			end
			if (!irqTimer)
			begin
				errors++;
				$display("Timeout waiting for timer irq");
			end
			else
				checkWord("timer irq latency", 16'(lat), 16'(len + 2));
		end
		writeReg(REG_IRQACK, 16'h0002);
		writeReg(REG_MODE, 16'h0020);	// Irq off
		writeReg(REG_TIMERLO, 16'($urandom_range(1, 40)));
		repeat (60) @(negedge CLK);
		checkWord("irqTimer while disabled", 16'(irqTimer), 16'd0);

		// Random acks around vblank with a repeating timer
		writeReg(REG_MODE, 16'h00B0);
		writeReg(REG_TIMERLO, 16'd700);
		repeat (2)
		begin
			waitLine(VBLANK_LINE - 1);
			repeat (24)
			begin
				writeReg(REG_IRQACK, 16'($urandom_range(0, 7)));
				repeat ($urandom_range(0, 200)) @(negedge CLK);
			end
		end

		monitorOn = 1'b0;
		$display("Checks: %0d  Errors: %0d", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// File: sim.f
src/lspcPkg.sv
src/lspcRegs.sv
src/vramPort.sv
src/lspcTimer.sv
src/videoCounters.sv
src/irqCtrl.sv
src/lspcCore.sv
sim/tbLspc.sv

// File: Makefile
TOP := tbLspc

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): sim.f src/*.sv sim/*.sv
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Errors found" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "No errors" sim.log

lint:
	verilator --lint-only -Wall --timing -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
